//--- ooo_pkg.sv
package ooo_pkg;

  // architectural registers including the hardwired r0
  localparam int REG_NUM = 16;

  typedef logic [31:0] word_t;
  typedef logic [3:0]  reg_idx_t;

  typedef enum logic [1:0] {
    OP_ADD = 2'b00,
    OP_SUB = 2'b01,
    OP_XOR = 2'b10,
    OP_MUL = 2'b11
  } alu_op_t;

  // RS_EXEC covers both issued and in flight
  typedef enum logic [1:0] {
    RS_FREE = 2'b00,
    RS_EXEC = 2'b01,
    RS_DONE = 2'b10
  } rob_state_t;

endpackage

//--- uop_if.sv
interface uop_if;

  logic              valid;
  logic              ready;
  ooo_pkg::alu_op_t  op;
  ooo_pkg::reg_idx_t rd;
  ooo_pkg::reg_idx_t rs1;
  ooo_pkg::reg_idx_t rs2;
  ooo_pkg::word_t    imm;
  logic              use_imm;

  // queue side
  modport src (
    output valid, op, rd, rs1, rs2, imm, use_imm,
    input  ready
  );

  // reorder buffer side
  modport dst (
    input  valid, op, rd, rs1, rs2, imm, use_imm,
    output ready
  );

endinterface

//--- exu_if.sv
interface exu_if #(
  parameter int ROB_SIZE = 8
);

  logic                        valid;
  logic                        ready;
  ooo_pkg::alu_op_t            op;
  ooo_pkg::word_t              opa;
  ooo_pkg::word_t              opb;
  // rob entry that receives the result
  logic [$clog2(ROB_SIZE)-1:0] tag;

  modport src (
    output valid, op, opa, opb, tag,
    input  ready
  );

  modport dst (
    input  valid, op, opa, opb, tag,
    output ready
  );

endinterface

//--- uop_queue.sv
module uop_queue #(
  parameter int QUEUE_SIZE = 4
) (
  input  logic              clock,
  input  logic              rst_n_i,
  input  logic              in_valid_i,
  output logic              in_ready_o,
  input  ooo_pkg::alu_op_t  in_op_i,
  input  ooo_pkg::reg_idx_t in_rd_i,
  input  ooo_pkg::reg_idx_t in_rs1_i,
  input  ooo_pkg::reg_idx_t in_rs2_i,
  input  ooo_pkg::word_t    in_imm_i,
  input  logic              in_use_imm_i,
  uop_if.src                uop
);

  localparam int PTR_W = $clog2(QUEUE_SIZE);
  localparam logic [PTR_W:0] FULL_CNT = (PTR_W + 1)'(QUEUE_SIZE);

  typedef logic [PTR_W-1:0] ptr_t;

  ptr_t           head;
  ptr_t           tail;
  logic [PTR_W:0] count;
  logic           push;
  logic           pop;

  ooo_pkg::alu_op_t  q_op      [QUEUE_SIZE];
  ooo_pkg::reg_idx_t q_rd      [QUEUE_SIZE];
  ooo_pkg::reg_idx_t q_rs1     [QUEUE_SIZE];
  ooo_pkg::reg_idx_t q_rs2     [QUEUE_SIZE];
  ooo_pkg::word_t    q_imm     [QUEUE_SIZE];
  logic              q_use_imm [QUEUE_SIZE];

  assign in_ready_o = (count != FULL_CNT);
  assign push       = in_valid_i && in_ready_o;
  assign pop        = uop.valid && uop.ready;

  // oldest entry sits at head
  assign uop.valid   = (count != '0);
  assign uop.op      = q_op[head];
  assign uop.rd      = q_rd[head];
  assign uop.rs1     = q_rs1[head];
  assign uop.rs2     = q_rs2[head];
  assign uop.imm     = q_imm[head];
  assign uop.use_imm = q_use_imm[head];

  always_ff @(posedge clock or negedge rst_n_i) begin
    if (!rst_n_i) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end else begin
      if (push) begin
        tail <= tail + 1'b1;
      end
      if (pop) begin
        head <= head + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (push) begin
      q_op[tail]      <= in_op_i;
      q_rd[tail]      <= in_rd_i;
      q_rs1[tail]     <= in_rs1_i;
      q_rs2[tail]     <= in_rs2_i;
      q_imm[tail]     <= in_imm_i;
      q_use_imm[tail] <= in_use_imm_i;
    end
  end

endmodule

//--- reorder_buffer.sv
module reorder_buffer #(
  parameter int ROB_SIZE = 8
) (
  input  logic                        clock,
  input  logic                        rst_n_i,
  uop_if.dst                          uop,
  exu_if.src                          exu,
  input  logic                        wb_valid_i,
  input  logic [$clog2(ROB_SIZE)-1:0] wb_tag_i,
  input  ooo_pkg::word_t              wb_data_i,
  output ooo_pkg::reg_idx_t           rf_rs1_o,
  output ooo_pkg::reg_idx_t           rf_rs2_o,
  input  ooo_pkg::word_t              rf_rdata1_i,
  input  ooo_pkg::word_t              rf_rdata2_i,
  output logic                        rf_we_o,
  output ooo_pkg::reg_idx_t           rf_wa_o,
  output ooo_pkg::word_t              rf_wd_o,
  output logic                        commit_valid_o,
  input  logic                        commit_ready_i,
  output ooo_pkg::reg_idx_t           commit_rd_o,
  output ooo_pkg::word_t              commit_data_o
);

  localparam int TAG_W = $clog2(ROB_SIZE);

  typedef logic [TAG_W-1:0] tag_t;

  tag_t rob_head;
  tag_t rob_tail;

  ooo_pkg::rob_state_t rob_state [ROB_SIZE];
  ooo_pkg::reg_idx_t   rob_rd    [ROB_SIZE];
  ooo_pkg::word_t      rob_value [ROB_SIZE];

  // producer index only meaningful while the register is busy
  logic [ooo_pkg::REG_NUM-1:0] reg_busy;
  tag_t                        reg_prod [ooo_pkg::REG_NUM];

  logic              src1_busy;
  logic              src2_busy;
  tag_t              src1_tag;
  tag_t              src2_tag;
  logic              src1_wait;
  logic              src2_wait;
  logic              rob_free;
  logic              dispatch;
  logic              commit;
  ooo_pkg::reg_idx_t head_rd;

  assign rf_rs1_o = uop.rs1;
  assign rf_rs2_o = uop.rs2;

  assign src1_busy = reg_busy[uop.rs1];
  assign src2_busy = reg_busy[uop.rs2];
  assign src1_tag  = reg_prod[uop.rs1];
  assign src2_tag  = reg_prod[uop.rs2];

  // stall while a producer is still executing
  assign src1_wait = src1_busy && (rob_state[src1_tag] != ooo_pkg::RS_DONE);
  assign src2_wait = !uop.use_imm && src2_busy && (rob_state[src2_tag] != ooo_pkg::RS_DONE);
  assign rob_free  = (rob_state[rob_tail] == ooo_pkg::RS_FREE);

  assign exu.valid = uop.valid && rob_free && !src1_wait && !src2_wait;
  assign exu.op    = uop.op;
  assign exu.tag   = rob_tail;
  assign exu.opa   = src1_busy ? rob_value[src1_tag] : rf_rdata1_i;
  assign exu.opb   = uop.use_imm ? uop.imm :
                     (src2_busy ? rob_value[src2_tag] : rf_rdata2_i);

  assign dispatch  = exu.valid && exu.ready;
  assign uop.ready = dispatch;

  // in-order retire from head
  assign head_rd        = rob_rd[rob_head];
  assign commit_valid_o = (rob_state[rob_head] == ooo_pkg::RS_DONE);
  assign commit         = commit_valid_o && commit_ready_i;
  assign commit_rd_o    = head_rd;
  assign commit_data_o  = rob_value[rob_head];

  assign rf_we_o = commit;
  assign rf_wa_o = head_rd;
  assign rf_wd_o = rob_value[rob_head];

  always_ff @(posedge clock or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rob_head <= '0;
      rob_tail <= '0;
      reg_busy <= '0;
      for (int i = 0; i < ROB_SIZE; i++) begin
        rob_state[i] <= ooo_pkg::RS_FREE;
      end
      for (int r = 0; r < ooo_pkg::REG_NUM; r++) begin
        reg_prod[r] <= '0;
      end
    end else begin
      if (dispatch) begin
        rob_tail            <= rob_tail + 1'b1;
        rob_state[rob_tail] <= ooo_pkg::RS_EXEC;
      end
      if (wb_valid_i) begin
        rob_state[wb_tag_i] <= ooo_pkg::RS_DONE;
      end
      if (commit) begin
        rob_head            <= rob_head + 1'b1;
        rob_state[rob_head] <= ooo_pkg::RS_FREE;
        // keep the mark if a younger producer took the register
        if (reg_prod[head_rd] == rob_head && !(dispatch && uop.rd == head_rd)) begin
          reg_busy[head_rd] <= 1'b0;
        end
      end
      if (dispatch && uop.rd != '0) begin
        reg_busy[uop.rd] <= 1'b1;
        reg_prod[uop.rd] <= rob_tail;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (dispatch) begin
      rob_rd[rob_tail] <= uop.rd;
    end
    if (wb_valid_i) begin
      rob_value[wb_tag_i] <= wb_data_i;
    end
  end

endmodule

//--- exec_unit.sv
module exec_unit #(
  parameter int ROB_SIZE = 8
) (
  input  logic                        clock,
  input  logic                        rst_n_i,
  exu_if.dst                          exu,
  output logic                        wb_valid_o,
  output logic [$clog2(ROB_SIZE)-1:0] wb_tag_o,
  output ooo_pkg::word_t              wb_data_o
);

  localparam int TAG_W = $clog2(ROB_SIZE);

  typedef logic [TAG_W-1:0] tag_t;

  logic           issue;
  ooo_pkg::word_t alu_next;

  logic           alu_valid;
  tag_t           alu_tag;
  ooo_pkg::word_t alu_res;

  // multiply pipe builds the low 32 bits from 16-bit halves
  logic           m1_valid;
  tag_t           m1_tag;
  ooo_pkg::word_t m1_ll;
  logic [15:0]    m1_lh;
  logic [15:0]    m1_hl;
  logic           m2_valid;
  tag_t           m2_tag;
  ooo_pkg::word_t m2_ll;
  logic [15:0]    m2_cross;
  logic           m3_valid;
  tag_t           m3_tag;
  ooo_pkg::word_t m3_prod;

  // a fast op now would retire together with the stage 2 multiply
  assign exu.ready = !m2_valid;
  assign issue     = exu.valid && exu.ready;

  always_comb begin
    case (exu.op)
      ooo_pkg::OP_SUB: alu_next = exu.opa - exu.opb;
      ooo_pkg::OP_XOR: alu_next = exu.opa ^ exu.opb;
      default:         alu_next = exu.opa + exu.opb;
    endcase
  end

  always_ff @(posedge clock or negedge rst_n_i) begin
    if (!rst_n_i) begin
      alu_valid <= 1'b0;
      m1_valid  <= 1'b0;
      m2_valid  <= 1'b0;
      m3_valid  <= 1'b0;
    end else begin
      alu_valid <= issue && (exu.op != ooo_pkg::OP_MUL);
      m1_valid  <= issue && (exu.op == ooo_pkg::OP_MUL);
      m2_valid  <= m1_valid;
      m3_valid  <= m2_valid;
    end
  end

  always_ff @(posedge clock) begin
    alu_tag  <= exu.tag;
    alu_res  <= alu_next;
    m1_tag   <= exu.tag;
    m1_ll    <= exu.opa[15:0] * exu.opb[15:0];
    m1_lh    <= exu.opa[15:0] * exu.opb[31:16];
    m1_hl    <= exu.opa[31:16] * exu.opb[15:0];
    m2_tag   <= m1_tag;
    m2_ll    <= m1_ll;
    m2_cross <= m1_lh + m1_hl;
    m3_tag   <= m2_tag;
    m3_prod  <= m2_ll + {m2_cross, 16'h0000};
  end

  // at most one lane finishes per cycle
  assign wb_valid_o = alu_valid || m3_valid;
  assign wb_tag_o   = m3_valid ? m3_tag : alu_tag;
  assign wb_data_o  = m3_valid ? m3_prod : alu_res;

endmodule

//--- arch_regfile.sv
module arch_regfile (
  input  logic              clock,
  input  logic              rst_n_i,
  input  ooo_pkg::reg_idx_t rs1_i,
  input  ooo_pkg::reg_idx_t rs2_i,
  output ooo_pkg::word_t    rdata1_o,
  output ooo_pkg::word_t    rdata2_o,
  input  logic              we_i,
  input  ooo_pkg::reg_idx_t wa_i,
  input  ooo_pkg::word_t    wd_i
);

  ooo_pkg::word_t regs [ooo_pkg::REG_NUM];

  always_ff @(posedge clock or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int r = 0; r < ooo_pkg::REG_NUM; r++) begin
        regs[r] <= '0;
      end
    end else if (we_i && wa_i != '0) begin
      regs[wa_i] <= wd_i;
    end
  end

  // r0 reads as zero
  assign rdata1_o = (rs1_i == '0) ? '0 : regs[rs1_i];
  assign rdata2_o = (rs2_i == '0) ? '0 : regs[rs2_i];

endmodule

//--- ooo_top.sv
module ooo_top #(
  parameter int QUEUE_SIZE = 4,
  parameter int ROB_SIZE   = 8
) (
  input  logic              clock,
  input  logic              rst_n_i,
  input  logic              in_valid_i,
  output logic              in_ready_o,
  input  ooo_pkg::alu_op_t  in_op_i,
  input  ooo_pkg::reg_idx_t in_rd_i,
  input  ooo_pkg::reg_idx_t in_rs1_i,
  input  ooo_pkg::reg_idx_t in_rs2_i,
  input  ooo_pkg::word_t    in_imm_i,
  input  logic              in_use_imm_i,
  output logic              commit_valid_o,
  input  logic              commit_ready_i,
  output ooo_pkg::reg_idx_t commit_rd_o,
  output ooo_pkg::word_t    commit_data_o
);

  logic                        wb_valid;
  logic [$clog2(ROB_SIZE)-1:0] wb_tag;
  ooo_pkg::word_t              wb_data;
  ooo_pkg::reg_idx_t           rf_rs1;
  ooo_pkg::reg_idx_t           rf_rs2;
  ooo_pkg::word_t              rf_rdata1;
  ooo_pkg::word_t              rf_rdata2;
  logic                        rf_we;
  ooo_pkg::reg_idx_t           rf_wa;
  ooo_pkg::word_t              rf_wd;

  uop_if                         uop_bus ();
  exu_if #(.ROB_SIZE(ROB_SIZE))  exu_bus ();

  uop_queue #(
    .QUEUE_SIZE(QUEUE_SIZE)
  ) queue_i (
    .clock        (clock),
    .rst_n_i      (rst_n_i),
    .in_valid_i   (in_valid_i),
    .in_ready_o   (in_ready_o),
    .in_op_i      (in_op_i),
    .in_rd_i      (in_rd_i),
    .in_rs1_i     (in_rs1_i),
    .in_rs2_i     (in_rs2_i),
    .in_imm_i     (in_imm_i),
    .in_use_imm_i (in_use_imm_i),
    .uop          (uop_bus.src)
  );

  reorder_buffer #(
    .ROB_SIZE(ROB_SIZE)
  ) rob_i (
    .clock          (clock),
    .rst_n_i        (rst_n_i),
    .uop            (uop_bus.dst),
    .exu            (exu_bus.src),
    .wb_valid_i     (wb_valid),
    .wb_tag_i       (wb_tag),
    .wb_data_i      (wb_data),
    .rf_rs1_o       (rf_rs1),
    .rf_rs2_o       (rf_rs2),
    .rf_rdata1_i    (rf_rdata1),
    .rf_rdata2_i    (rf_rdata2),
    .rf_we_o        (rf_we),
    .rf_wa_o        (rf_wa),
    .rf_wd_o        (rf_wd),
    .commit_valid_o (commit_valid_o),
    .commit_ready_i (commit_ready_i),
    .commit_rd_o    (commit_rd_o),
    .commit_data_o  (commit_data_o)
  );

  exec_unit #(
    .ROB_SIZE(ROB_SIZE)
  ) exu_i (
    .clock      (clock),
    .rst_n_i    (rst_n_i),
    .exu        (exu_bus.dst),
    .wb_valid_o (wb_valid),
    .wb_tag_o   (wb_tag),
    .wb_data_o  (wb_data)
  );

  arch_regfile regfile_i (
    .clock    (clock),
    .rst_n_i  (rst_n_i),
    .rs1_i    (rf_rs1),
    .rs2_i    (rf_rs2),
    .rdata1_o (rf_rdata1),
    .rdata2_o (rf_rdata2),
    .we_i     (rf_we),
    .wa_i     (rf_wa),
    .wd_i     (rf_wd)
  );

endmodule

//--- tb_ooo.sv
module tb_ooo;

  localparam int QUEUE_SIZE     = 4;
  localparam int ROB_SIZE       = 8;
  localparam int N_MIXED        = 60;
  localparam int N_CHAIN        = 60;
  localparam int N_BP           = 40;
  localparam int N_STALL        = 24;
  localparam int N_ZERO         = 36;
  localparam int N_GAPS         = 40;
  localparam int TOTAL_UOPS     = N_MIXED + N_CHAIN + N_BP + N_STALL + N_ZERO + N_GAPS;
  localparam int TIMEOUT_CYCLES = 40 * TOTAL_UOPS + 200;

  logic              clock;
  logic              rst_n_i;
  logic              in_valid_i;
  logic              in_ready_o;
  ooo_pkg::alu_op_t  in_op_i;
  ooo_pkg::reg_idx_t in_rd_i;
  ooo_pkg::reg_idx_t in_rs1_i;
  ooo_pkg::reg_idx_t in_rs2_i;
  ooo_pkg::word_t    in_imm_i;
  logic              in_use_imm_i;
  logic              commit_valid_o;
  logic              commit_ready_i;
  ooo_pkg::reg_idx_t commit_rd_o;
  ooo_pkg::word_t    commit_data_o;

  integer seed    = 32'h40761943;
  // commit side draws from its own stream
  integer bp_seed = ~32'h40761943;

  int   errors       = 0;
  int   accept_count = 0;
  int   commit_count = 0;
  logic hold_commit  = 1'b0;
  logic bp_random    = 1'b0;
  logic full_seen    = 1'b0;

  ooo_pkg::word_t    ref_regs [ooo_pkg::REG_NUM];
  ooo_pkg::reg_idx_t exp_rd_q [$];
  ooo_pkg::word_t    exp_data_q [$];

  ooo_top #(
    .QUEUE_SIZE(QUEUE_SIZE),
    .ROB_SIZE  (ROB_SIZE)
  ) dut_i (
    .clock          (clock),
    .rst_n_i        (rst_n_i),
    .in_valid_i     (in_valid_i),
    .in_ready_o     (in_ready_o),
    .in_op_i        (in_op_i),
    .in_rd_i        (in_rd_i),
    .in_rs1_i       (in_rs1_i),
    .in_rs2_i       (in_rs2_i),
    .in_imm_i       (in_imm_i),
    .in_use_imm_i   (in_use_imm_i),
    .commit_valid_o (commit_valid_o),
    .commit_ready_i (commit_ready_i),
    .commit_rd_o    (commit_rd_o),
    .commit_data_o  (commit_data_o)
  );

  initial begin
    clock = 1'b0;
    forever #2 clock = ~clock;
  end

  // program-order model of the architectural registers
  function automatic ooo_pkg::word_t model_execute(input ooo_pkg::alu_op_t op,
      input ooo_pkg::reg_idx_t rd, input ooo_pkg::reg_idx_t rs1,
      input ooo_pkg::reg_idx_t rs2, input ooo_pkg::word_t imm, input logic use_imm);
    ooo_pkg::word_t a;
    ooo_pkg::word_t b;
    ooo_pkg::word_t res;
    a = (rs1 == 4'd0) ? 32'd0 : ref_regs[rs1];
    b = use_imm ? imm : ((rs2 == 4'd0) ? 32'd0 : ref_regs[rs2]);
    case (op)
      ooo_pkg::OP_ADD: res = a + b;
      ooo_pkg::OP_SUB: res = a - b;
      ooo_pkg::OP_XOR: res = a ^ b;
      default:         res = a * b;
    endcase
    if (rd != 4'd0) begin
      ref_regs[rd] = res;
    end
    return res;
  endfunction

  // called a little after a rising edge, returns the same way
  task automatic send_uop(input ooo_pkg::alu_op_t op, input ooo_pkg::reg_idx_t rd,
      input ooo_pkg::reg_idx_t rs1, input ooo_pkg::reg_idx_t rs2,
      input ooo_pkg::word_t imm, input logic use_imm);
    in_valid_i   = 1'b1;
    in_op_i      = op;
    in_rd_i      = rd;
    in_rs1_i     = rs1;
    in_rs2_i     = rs2;
    in_imm_i     = imm;
    in_use_imm_i = use_imm;
    @(negedge clock);
    while (!in_ready_o) begin
      @(negedge clock);
    end
    exp_rd_q.push_back(rd);
    exp_data_q.push_back(model_execute(op, rd, rs1, rs2, imm, use_imm));
    accept_count++;
    @(posedge clock);
    #1;
    in_valid_i = 1'b0;
  endtask

  task automatic send_random(input int count, input int reg_lo, input int reg_span,
      input int max_gap);
    ooo_pkg::alu_op_t  op;
    ooo_pkg::reg_idx_t rd;
    ooo_pkg::reg_idx_t rs1;
    ooo_pkg::reg_idx_t rs2;
    ooo_pkg::word_t    imm;
    logic              use_imm;
    int                gaps;
    for (int k = 0; k < count; k++) begin
      op      = ooo_pkg::alu_op_t'(2'($random(seed)));
      rd      = ooo_pkg::reg_idx_t'(reg_lo + $unsigned($random(seed)) % reg_span);
      rs1     = ooo_pkg::reg_idx_t'(reg_lo + $unsigned($random(seed)) % reg_span);
      rs2     = ooo_pkg::reg_idx_t'(reg_lo + $unsigned($random(seed)) % reg_span);
      imm     = $random(seed);
      use_imm = (2'($random(seed)) == 2'd0);
      send_uop(op, rd, rs1, rs2, imm, use_imm);
      gaps = $unsigned($random(seed)) % (max_gap + 1);
      repeat (gaps) begin
        @(posedge clock);
        #1;
      end
    end
  endtask

  task automatic check_idle(input string when_s);
    if (commit_valid_o !== 1'b0) begin
      $display("[ERROR] %0t: commit_valid_o not low %s", $time, when_s);
      errors++;
    end
    if (in_ready_o !== 1'b1) begin
      $display("[ERROR] %0t: in_ready_o not high %s", $time, when_s);
      errors++;
    end
  endtask

  task automatic drain_and_count();
    while (exp_rd_q.size() != 0) begin
      @(negedge clock);
    end
    repeat (3) @(negedge clock);
    if (commit_count != accept_count) begin
      $display("[ERROR] %0t: %0d commits for %0d accepted micro-ops", $time,
               commit_count, accept_count);
      errors++;
    end
    if (commit_valid_o !== 1'b0) begin
      $display("[ERROR] %0t: commit_valid_o high with nothing outstanding", $time);
      errors++;
    end
    @(posedge clock);
    #1;
  endtask

  always @(negedge clock) begin : compare_commits
    ooo_pkg::reg_idx_t exp_rd;
    ooo_pkg::word_t    exp_data;
    if (rst_n_i && commit_valid_o && commit_ready_i) begin
      commit_count++;
      if (exp_rd_q.size() == 0) begin
        $display("a commit appeared at time %0t with no micro-op outstanding", $time);
        errors++;
      end else begin
        exp_rd   = exp_rd_q.pop_front();
        exp_data = exp_data_q.pop_front();
        if (commit_rd_o !== exp_rd) begin
          $display("[ERROR] %0t: commit rd %0d, expected %0d", $time, commit_rd_o, exp_rd);
          errors++;
        end
        if (commit_data_o !== exp_data) begin
          $display("[ERROR] %0t: commit data %h, expected %h", $time, commit_data_o,
                   exp_data);
          errors++;
        end
      end
    end
  end

  initial begin : commit_driver
    forever begin
      @(posedge clock);
      #1;
      if (hold_commit) begin
        commit_ready_i = 1'b0;
      end else if (bp_random) begin
        commit_ready_i = (2'($random(bp_seed)) != 2'd0);
      end else begin
        commit_ready_i = 1'b1;
      end
    end
  end

  // lets commits go again a few cycles after the input side is full
  initial begin : stall_release
    forever begin
      @(negedge clock);
      if (hold_commit && !in_ready_o) begin
        full_seen = 1'b1;
        repeat (6) @(negedge clock);
        hold_commit = 1'b0;
      end
    end
  end

  initial begin : watchdog
    repeat (TIMEOUT_CYCLES) @(posedge clock);
    $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("Verification failed");
    $finish;
  end

  initial begin : main
    for (int r = 0; r < ooo_pkg::REG_NUM; r++) begin
      ref_regs[r] = '0;
    end
    rst_n_i        = 1'b0;
    in_valid_i     = 1'b0;
    in_op_i        = ooo_pkg::OP_ADD;
    in_rd_i        = '0;
    in_rs1_i       = '0;
    in_rs2_i       = '0;
    in_imm_i       = '0;
    in_use_imm_i   = 1'b0;
    commit_ready_i = 1'b0;
    repeat (5) begin
      @(posedge clock);
      #1;
      check_idle("during reset");
    end
    rst_n_i = 1'b1;
    @(negedge clock);
    check_idle("after reset");
    @(posedge clock);
    #1;

    send_random(N_MIXED, 0, 16, 0);
    drain_and_count();
    // short chains through r1..r3
    send_random(N_CHAIN, 1, 3, 0);
    drain_and_count();

    bp_random = 1'b1;
    send_random(N_BP, 0, 16, 1);
    drain_and_count();
    full_seen   = 1'b0;
    hold_commit = 1'b1;
    send_random(N_STALL, 0, 16, 0);
    hold_commit = 1'b0;
    drain_and_count();
    if (!full_seen) begin
      $display("the input side never backed up while commits were held");
      errors++;
    end
    bp_random = 1'b0;

    // writes to r0 commit their data, reads of r0 still see zero
    send_uop(ooo_pkg::OP_ADD, 4'd0, 4'd0, 4'd0, 32'h0000_1234, 1'b1);
    send_uop(ooo_pkg::OP_ADD, 4'd1, 4'd0, 4'd0, 32'h0000_0011, 1'b1);
    send_uop(ooo_pkg::OP_MUL, 4'd0, 4'd1, 4'd1, 32'h0, 1'b0);
    send_uop(ooo_pkg::OP_SUB, 4'd2, 4'd0, 4'd1, 32'h0, 1'b0);
    send_uop(ooo_pkg::OP_XOR, 4'd0, 4'd2, 4'd0, 32'h0000_00ff, 1'b1);
    send_uop(ooo_pkg::OP_ADD, 4'd3, 4'd0, 4'd2, 32'h0, 1'b0);
    send_random(N_ZERO - 6, 0, 2, 0);
    drain_and_count();

    bp_random = 1'b1;
    send_random(N_GAPS, 0, 8, 3);
    drain_and_count();

    $display("checks done: %0d errors, %0d accepted, %0d committed", errors,
             accept_count, commit_count);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

//--- verilog.f
ooo_pkg.sv
uop_if.sv
exu_if.sv
uop_queue.sv
reorder_buffer.sv
exec_unit.sv
arch_regfile.sv
ooo_top.sv
tb_ooo.sv

//--- Makefile
TOP := tb_ooo

sim:
	verilator --binary --timing --top-module $(TOP) -f verilog.f -o $(TOP)
	@out="$$(./obj_dir/$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "Verification passed"

clean:
	rm -rf obj_dir

.PHONY: sim clean
